// ==== src/bif_cfg.svh ====
// Fixed bus interface widths, included by the packages and RTL before any width is used
`ifndef BIF_CFG_SVH
`define BIF_CFG_SVH

// Physical page number, upper address bits
`define BIF_PAGE_W 14

// Word offset inside a page
`define BIF_OFFS_W 10

// CPU and memory data word
`define BIF_DATA_W 16

// Local bus, page plus offset
`define BIF_LBD_W 24

// Unused upper bits when a data word rides the local bus
`define BIF_PAD_W (`BIF_LBD_W - `BIF_DATA_W)

`endif

// ==== src/bif_bus_pkg.sv ====
// Local bus word types, imported by the ports, arbiter and error registers
`include "bif_cfg.svh"

package bif_bus_pkg;

  // Address view of a local bus word
  typedef struct packed {
    logic [`BIF_PAGE_W-1:0] page;  // Physical page number
    logic [`BIF_OFFS_W-1:0] offs;  // Word offset in page
  } lbd_addr_t;

  // Data view of a local bus word
  typedef struct packed {
    logic [`BIF_PAD_W-1:0]  pad;   // Zero on writes
    logic [`BIF_DATA_W-1:0] data;  // Data word
  } lbd_data_t;

  // One local bus word, decoded as address or as data
  typedef union packed {
    lbd_addr_t addr;  // Used by PEA and address phase
    lbd_data_t dat;   // Used by ports for data
  } lbd_word_u;

endpackage

// ==== src/bif_ctl_pkg.sv ====
// Control types for bus ownership, arbiter states and PES status, imported where needed
`include "bif_cfg.svh"

package bif_ctl_pkg;

  // Local bus owner
  typedef enum logic {
    owner_cpu = 1'b0,
    owner_ext = 1'b1
  } owner_e;

  // Arbiter and memory handshake states
  typedef enum logic [1:0] {
    arb_idle    = 2'd0,  // Waiting for a peer request
    arb_mreq    = 2'd1,  // mem_req high, waiting for mem_ack
    arb_ack     = 2'd2,  // Owner ack raised
    arb_release = 2'd3   // Waiting for owner req and mem_ack low
  } arb_state_e;

  // Parity error status word, read on IDB
  typedef struct packed {
    logic                     valid;    // Error recorded
    owner_e                   owner;    // Failing owner
    logic                     write;    // Failing cycle was a write
    logic                     overrun;  // Later error before clear
    logic [`BIF_DATA_W-5:0]   zero;     // Reads as zero
  } pes_t;

endpackage

// ==== src/bif_cpu_port.sv ====
// CPU side of the bus interface, latches a CPU request and returns read data on cpu_rdata
`timescale 1ns/1ps
`include "bif_cfg.svh"

module bif_cpu_port
  import bif_bus_pkg::*;
(
  input  logic                   clkbd,
  input  logic                   rst_n,
  input  logic                   cpu_req,     // Four-phase request from CPU
  input  logic                   cpu_write,   // 1 = write cycle
  input  logic [`BIF_PAGE_W-1:0] cpu_ppn,     // Physical page number
  input  logic [`BIF_OFFS_W-1:0] cpu_ca,      // Word offset
  input  logic [`BIF_DATA_W-1:0] cpu_wdata,
  input  logic                   grant_ack,   // Arbiter done for this port
  input  lbd_word_u              rdata,       // Shared read word from arbiter
  output logic                   cpu_ack,
  output logic [`BIF_DATA_W-1:0] cpu_rdata,
  output logic                   port_req,    // Request to arbiter
  output logic                   port_write,
  output lbd_word_u              port_addr,   // Address view filled
  output lbd_word_u              port_wdata   // Data view filled
);

  localparam logic [1:0] st_idle  = 2'd0;  // Waiting for cpu_req
  localparam logic [1:0] st_latch = 2'd1;  // Request latched
  localparam logic [1:0] st_req   = 2'd2;  // Waiting for arbiter ack
  localparam logic [1:0] st_ack   = 2'd3;  // cpu_ack high

  logic [1:0] st_q;

  always_ff @(posedge clkbd or negedge rst_n) begin
    if (!rst_n) begin
      st_q       <= st_idle;
      port_req   <= 1'b0;
      port_write <= 1'b0;
      cpu_ack    <= 1'b0;
    end else begin
      case (st_q)
        st_idle: if (cpu_req) begin
          port_write <= cpu_write;  // Held for the whole cycle
          st_q       <= st_latch;
        end
        st_latch: begin
          port_req <= 1'b1;  // One cycle after latch
          st_q     <= st_req;
        end
        st_req: if (grant_ack) begin
          port_req <= 1'b0;
          cpu_ack  <= 1'b1;
          st_q     <= st_ack;
        end
        default: if (!cpu_req && !grant_ack) begin
          // Arbiter ack also low so a new cycle starts clean
          cpu_ack <= 1'b0;
          st_q    <= st_idle;
        end
      endcase
    end
  end

  // Address and data payload, PPN joined with offset
  always_ff @(posedge clkbd) begin
    if (st_q == st_idle && cpu_req) begin
      port_addr.addr.page <= cpu_ppn;
      port_addr.addr.offs <= cpu_ca;
      port_wdata.dat.pad  <= '0;
      port_wdata.dat.data <= cpu_wdata;
    end
  end

  // Read data held until the next cycle completes
  always_ff @(posedge clkbd) begin
    if (st_q == st_req && grant_ack) begin
      cpu_rdata <= rdata.dat.data;
    end
  end

endmodule

// ==== src/bif_ext_port.sv ====
// External bus side of the interface, converts the inverted multiplexed bus to local bus words
`timescale 1ns/1ps
`include "bif_cfg.svh"

module bif_ext_port
  import bif_bus_pkg::*;
(
  input  logic                  clkbd,
  input  logic                  rst_n,
  input  logic                  bus_dap_n,   // Address present strobe
  input  logic                  bus_req,     // Four-phase request
  input  logic                  bus_write,   // 1 = write cycle
  input  logic [`BIF_LBD_W-1:0] bd_in_n,     // Inverted address or data
  input  logic                  grant_ack,   // Arbiter done for this port
  input  lbd_word_u             rdata,       // Shared read word from arbiter
  output logic                  bus_ack,
  output logic [`BIF_LBD_W-1:0] bd_out_n,    // Inverted read data
  output logic                  port_req,    // Request to arbiter
  output logic                  port_write,
  output lbd_word_u             port_addr,
  output lbd_word_u             port_wdata
);

  localparam logic [1:0] st_idle  = 2'd0;  // Waiting for bus_req
  localparam logic [1:0] st_latch = 2'd1;  // Data latched
  localparam logic [1:0] st_req   = 2'd2;  // Waiting for arbiter ack
  localparam logic [1:0] st_ack   = 2'd3;  // bus_ack high

  logic [1:0] st_q;
  lbd_word_u  bd_in;    // True polarity bus word
  lbd_data_t  rd_q;     // Read word for the bus

  assign bd_in = ~bd_in_n;

  always_ff @(posedge clkbd or negedge rst_n) begin
    if (!rst_n) begin
      st_q       <= st_idle;
      port_req   <= 1'b0;
      port_write <= 1'b0;
      bus_ack    <= 1'b0;
    end else begin
      case (st_q)
        st_idle: if (bus_req) begin
          port_write <= bus_write;
          st_q       <= st_latch;
        end
        st_latch: begin
          port_req <= 1'b1;
          st_q     <= st_req;
        end
        st_req: if (grant_ack) begin
          port_req <= 1'b0;
          bus_ack  <= 1'b1;
          st_q     <= st_ack;
        end
        default: if (!bus_req && !grant_ack) begin
          bus_ack <= 1'b0;
          st_q    <= st_idle;
        end
      endcase
    end
  end

  // Address phase, only between cycles
  always_ff @(posedge clkbd) begin
    if (st_q == st_idle && !bus_dap_n) begin
      port_addr <= bd_in;
    end
  end

  // Write data from low bits at the request
  always_ff @(posedge clkbd) begin
    if (st_q == st_idle && bus_req) begin
      port_wdata.dat.pad  <= '0;
      port_wdata.dat.data <= bd_in.dat.data;
    end
  end

  always_ff @(posedge clkbd) begin
    if (st_q == st_req && grant_ack) begin
      rd_q.pad  <= '0;
      rd_q.data <= rdata.dat.data;
    end
  end

  // Bus released (all ones) except during a read ack
  assign bd_out_n = (bus_ack && !port_write) ? ~rd_q : '1;

endmodule

// ==== src/bif_lbd_arbiter.sv ====
// Round-robin local bus arbiter, muxes the granted peer onto the bus and runs the memory handshake
`timescale 1ns/1ps
`include "bif_cfg.svh"

module bif_lbd_arbiter
  import bif_bus_pkg::*;
  import bif_ctl_pkg::*;
(
  input  logic                  clkbd,
  input  logic                  rst_n,
  input  logic                  cpu_req,
  input  logic                  cpu_write,
  input  lbd_word_u             cpu_addr,
  input  lbd_word_u             cpu_wdata,
  input  logic                  ext_req,
  input  logic                  ext_write,
  input  lbd_word_u             ext_addr,
  input  lbd_word_u             ext_wdata,
  input  logic                  mem_ack,        // Memory four-phase ack
  input  lbd_word_u             mem_rdata,
  input  logic                  mem_err,        // Valid with mem_ack
  output logic                  cpu_grant_ack,
  output logic                  ext_grant_ack,
  output lbd_word_u             rdata,          // Captured at mem_ack
  output logic                  mem_req,
  output logic                  mem_write,
  output lbd_word_u             lbd_addr,
  output lbd_word_u             lbd_wdata,
  output logic                  err_strobe,     // One cycle per failing access
  output owner_e                err_owner,
  output logic                  err_write,
  output lbd_word_u             err_addr
);

  arb_state_e state_q;
  owner_e     owner_q;     // Current owner
  owner_e     last_q;      // Last granted owner
  owner_e     win;         // Winner in idle
  logic       any_req;
  logic       owner_req;   // Request line of current owner
  logic       grant_q;     // Ack to current owner

  assign any_req = cpu_req | ext_req;

  // Collision goes to the peer that was not last owner
  always_comb begin
    if (cpu_req && ext_req) begin
      win = (last_q == owner_ext) ? owner_cpu : owner_ext;
    end else if (cpu_req) begin
      win = owner_cpu;
    end else begin
      win = owner_ext;
    end
  end

  assign owner_req = (owner_q == owner_cpu) ? cpu_req : ext_req;

  always_ff @(posedge clkbd or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= arb_idle;
      owner_q    <= owner_cpu;
      last_q     <= owner_ext;  // CPU wins the first collision
      grant_q    <= 1'b0;
      mem_req    <= 1'b0;
      mem_write  <= 1'b0;
      err_strobe <= 1'b0;
    end else begin
      err_strobe <= 1'b0;  // Pulse only
      case (state_q)
        arb_idle: if (any_req) begin
          owner_q   <= win;
          last_q    <= win;
          mem_write <= (win == owner_cpu) ? cpu_write : ext_write;
          mem_req   <= 1'b1;
          state_q   <= arb_mreq;
        end
        arb_mreq: if (mem_ack) begin
          mem_req    <= 1'b0;
          grant_q    <= 1'b1;
          err_strobe <= mem_err;
          state_q    <= arb_ack;
        end
        arb_ack: state_q <= arb_release;
        default: if (!owner_req && !mem_ack) begin
          // Both handshakes back to rest
          grant_q <= 1'b0;
          state_q <= arb_idle;
        end
      endcase
    end
  end

  // Winner's words held on the local bus for the cycle
  always_ff @(posedge clkbd) begin
    if (state_q == arb_idle && any_req) begin
      lbd_addr  <= (win == owner_cpu) ? cpu_addr : ext_addr;
      lbd_wdata <= (win == owner_cpu) ? cpu_wdata : ext_wdata;
    end
  end

  always_ff @(posedge clkbd) begin
    if (state_q == arb_mreq && mem_ack) begin
      rdata <= mem_rdata;
    end
  end

  assign cpu_grant_ack = grant_q && (owner_q == owner_cpu);
  assign ext_grant_ack = grant_q && (owner_q == owner_ext);

  // Error details stay stable until the next grant
  assign err_owner = owner_q;
  assign err_write = mem_write;
  assign err_addr  = lbd_addr;

endmodule

// ==== src/bif_err_regs.sv ====
// PES and PEA parity error registers, captured on err_strobe and read on the internal data bus
`timescale 1ns/1ps
`include "bif_cfg.svh"

module bif_err_regs
  import bif_bus_pkg::*;
  import bif_ctl_pkg::*;
(
  input  logic                   clkbd,
  input  logic                   rst_n,
  input  logic                   err_strobe,  // Memory error seen
  input  owner_e                 err_owner,
  input  logic                   err_write,
  input  lbd_word_u              err_addr,    // Decoded as page and offset
  input  logic [1:0]             err_sel,     // IDB field select
  input  logic                   err_clr,     // Clears PES and PEA
  output logic [`BIF_DATA_W-1:0] idb
);

  pes_t      pes_q;  // Status
  lbd_word_u pea_q;  // Failing address

  always_ff @(posedge clkbd or negedge rst_n) begin
    if (!rst_n) begin
      pes_q <= '0;
      pea_q <= '0;
    end else if (err_clr) begin
      pes_q <= '0;
      pea_q <= '0;
    end else if (err_strobe) begin
      if (!pes_q.valid) begin
        // First error, full capture
        pes_q.valid   <= 1'b1;
        pes_q.owner   <= err_owner;
        pes_q.write   <= err_write;
        pes_q.overrun <= 1'b0;
        pes_q.zero    <= '0;
        pea_q         <= err_addr;
      end else begin
        pes_q.overrun <= 1'b1;  // PEA keeps first address
      end
    end
  end

  always_comb begin
    case (err_sel)
      2'd0:    idb = pes_q;
      2'd1:    idb = `BIF_DATA_W'(pea_q.addr.page);  // Zero extended
      2'd2:    idb = `BIF_DATA_W'(pea_q.addr.offs);
      default: idb = '0;
    endcase
  end

endmodule

// ==== src/bif_dpath.sv ====
// Bus interface data path top, joins CPU and external ports to local memory through the arbiter
`timescale 1ns/1ps
`include "bif_cfg.svh"

module bif_dpath
  import bif_bus_pkg::*;
  import bif_ctl_pkg::*;
(
  input  logic                   clkbd,
  input  logic                   rst_n,
  input  logic                   cpu_req,
  input  logic                   cpu_write,
  input  logic [`BIF_PAGE_W-1:0] cpu_ppn,
  input  logic [`BIF_OFFS_W-1:0] cpu_ca,
  input  logic [`BIF_DATA_W-1:0] cpu_wdata,
  output logic                   cpu_ack,
  output logic [`BIF_DATA_W-1:0] cpu_rdata,
  input  logic                   bus_dap_n,
  input  logic                   bus_req,
  input  logic                   bus_write,
  input  logic [`BIF_LBD_W-1:0]  bd_in_n,
  output logic                   bus_ack,
  output logic [`BIF_LBD_W-1:0]  bd_out_n,
  output logic                   mem_req,
  output logic                   mem_write,
  output logic [`BIF_LBD_W-1:0]  lbd_addr,
  output logic [`BIF_LBD_W-1:0]  lbd_wdata,
  input  logic                   mem_ack,
  input  logic [`BIF_LBD_W-1:0]  mem_rdata,
  input  logic                   mem_err,
  input  logic [1:0]             err_sel,
  input  logic                   err_clr,
  output logic [`BIF_DATA_W-1:0] idb
);

  logic      cpu_port_req, cpu_port_write, cpu_grant_ack;  // CPU port to arbiter
  lbd_word_u cpu_port_addr, cpu_port_wdata;
  logic      ext_port_req, ext_port_write, ext_grant_ack;  // External port to arbiter
  lbd_word_u ext_port_addr, ext_port_wdata;
  lbd_word_u rdata;                                        // Shared read word
  logic      err_strobe, err_write;
  owner_e    err_owner;
  lbd_word_u err_addr;

  bif_cpu_port i_cpu_port (
    .clkbd      (clkbd),
    .rst_n      (rst_n),
    .cpu_req    (cpu_req),
    .cpu_write  (cpu_write),
    .cpu_ppn    (cpu_ppn),
    .cpu_ca     (cpu_ca),
    .cpu_wdata  (cpu_wdata),
    .grant_ack  (cpu_grant_ack),
    .rdata      (rdata),
    .cpu_ack    (cpu_ack),
    .cpu_rdata  (cpu_rdata),
    .port_req   (cpu_port_req),
    .port_write (cpu_port_write),
    .port_addr  (cpu_port_addr),
    .port_wdata (cpu_port_wdata)
  );

  bif_ext_port i_ext_port (
    .clkbd      (clkbd),
    .rst_n      (rst_n),
    .bus_dap_n  (bus_dap_n),
    .bus_req    (bus_req),
    .bus_write  (bus_write),
    .bd_in_n    (bd_in_n),
    .grant_ack  (ext_grant_ack),
    .rdata      (rdata),
    .bus_ack    (bus_ack),
    .bd_out_n   (bd_out_n),
    .port_req   (ext_port_req),
    .port_write (ext_port_write),
    .port_addr  (ext_port_addr),
    .port_wdata (ext_port_wdata)
  );

  bif_lbd_arbiter i_arbiter (
    .clkbd         (clkbd),
    .rst_n         (rst_n),
    .cpu_req       (cpu_port_req),
    .cpu_write     (cpu_port_write),
    .cpu_addr      (cpu_port_addr),
    .cpu_wdata     (cpu_port_wdata),
    .ext_req       (ext_port_req),
    .ext_write     (ext_port_write),
    .ext_addr      (ext_port_addr),
    .ext_wdata     (ext_port_wdata),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .mem_err       (mem_err),
    .cpu_grant_ack (cpu_grant_ack),
    .ext_grant_ack (ext_grant_ack),
    .rdata         (rdata),
    .mem_req       (mem_req),
    .mem_write     (mem_write),
    .lbd_addr      (lbd_addr),
    .lbd_wdata     (lbd_wdata),
    .err_strobe    (err_strobe),
    .err_owner     (err_owner),
    .err_write     (err_write),
    .err_addr      (err_addr)
  );

  bif_err_regs i_err_regs (
    .clkbd      (clkbd),
    .rst_n      (rst_n),
    .err_strobe (err_strobe),
    .err_owner  (err_owner),
    .err_write  (err_write),
    .err_addr   (err_addr),
    .err_sel    (err_sel),
    .err_clr    (err_clr),
    .idb        (idb)
  );

endmodule

// ==== tb/tb_bif_tasks.svh ====
// Value check, local memory model and peer driver tasks, included by the testbench top
`ifndef TB_BIF_TASKS_SVH
`define TB_BIF_TASKS_SVH

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
  end
endtask

// Power-up contents from every address bit
function automatic logic [15:0] fill_word(input logic [9:0] idx);
  return {idx, idx[9:4]} ^ 16'h3c5a;
endfunction

task automatic wait_cpu_ack(input logic level);
  int n;
  n = 0;
  while (cpu_ack !== level && n < hs_limit) begin
    @(posedge clkbd);
    n++;
  end
  if (cpu_ack !== level) begin
    $display("CPU handshake stuck at %0t ns, cpu_ack never went to %0b", $time, level);
    hs_err_cnt++;
  end
endtask

task automatic wait_bus_ack(input logic level);
  int n;
  n = 0;
  while (bus_ack !== level && n < hs_limit) begin
    @(posedge clkbd);
    n++;
  end
  if (bus_ack !== level) begin
    $display("External bus handshake stuck at %0t ns, bus_ack never went to %0b", $time, level);
    hs_err_cnt++;
  end
endtask

// Four-phase local memory with random ack latency
task automatic serve_memory();
  int          lat;
  logic [23:0] addr;
  forever begin
    @(posedge clkbd);
    if (mem_req === 1'b1 && mem_ack === 1'b0) begin
      addr = lbd_addr;
      acc_log.push_back(addr);  // One entry per mem_req cycle
      lat = {$random(seed)} % (max_lat + 1);
      repeat (lat) @(posedge clkbd);
      check("lbd_addr held", lbd_addr, addr);
      if (mem_write) begin
        mem[addr[9:0]] = lbd_wdata[15:0];  // Low bits index
      end
      mem_rdata <= {8'h00, mem[addr[9:0]]};
      mem_err   <= (addr == bad_addr);
      mem_ack   <= 1'b1;
      @(posedge clkbd);
      while (mem_req === 1'b1) @(posedge clkbd);  // Wait for mem_req low
      mem_ack <= 1'b0;
      mem_err <= 1'b0;
    end
  end
endtask

task automatic cpu_access(input logic wr, input logic [13:0] page, input logic [9:0] offs,
                          input logic [15:0] wdata, output logic [15:0] rdata);
  @(posedge clkbd);
  cpu_write <= wr;
  cpu_ppn   <= page;
  cpu_ca    <= offs;
  cpu_wdata <= wdata;
  cpu_req   <= 1'b1;
  @(posedge clkbd);
  wait_cpu_ack(1'b1);
  rdata      = cpu_rdata;
  last_owner = owner_cpu;  // Service order follows ack order
  if (wr) begin
    exp_mem[offs] = wdata;
  end else begin
    check("cpu_rdata", cpu_rdata, exp_mem[offs]);
  end
  cpu_req <= 1'b0;
  @(posedge clkbd);
  wait_cpu_ack(1'b0);
endtask

task automatic ext_access(input logic wr, input logic [23:0] addr, input logic [15:0] wdata,
                          output logic [15:0] rdata);
  @(posedge clkbd);
  bus_dap_n <= 1'b0;  // Inverted address phase
  bd_in_n   <= ~addr;
  @(posedge clkbd);
  bus_dap_n <= 1'b1;
  bus_write <= wr;
  bd_in_n   <= ~{8'h00, wdata};
  bus_req   <= 1'b1;
  @(posedge clkbd);
  wait_bus_ack(1'b1);
  rdata      = ~bd_out_n[15:0];
  last_owner = owner_ext;
  if (wr) begin
    check("bd_out_n", bd_out_n, 24'hffffff);
    exp_mem[addr[9:0]] = wdata;
  end else begin
    check("bd_out_n", bd_out_n, {8'hff, ~exp_mem[addr[9:0]]});
  end
  bus_req <= 1'b0;
  bd_in_n <= '1;
  @(posedge clkbd);
  wait_bus_ack(1'b0);
  check("bd_out_n idle", bd_out_n, 24'hffffff);
endtask

task automatic compare_idb(input logic [1:0] sel, input logic [15:0] exp);
  @(posedge clkbd);
  err_sel <= sel;
  @(posedge clkbd);
  check($sformatf("idb sel %0d", sel), idb, exp);
endtask

`endif

// ==== tb/tb_bif_dpath.sv ====
// Directed testbench for the bus interface data path, run with the sources in list.f
`timescale 1ns/1ps
`include "bif_cfg.svh"

module tb_bif_dpath
  import bif_ctl_pkg::*;
;

  localparam int          hs_limit   = 100;          // Cycles per handshake wait
  localparam int          max_lat    = 7;            // Worst mem_ack delay
  localparam int          n_rand     = 24;
  localparam int          n_access   = 11 + n_rand;  // All peer accesses
  localparam int          max_cycles = 40 * n_access;
  localparam logic [13:0] err_page   = 14'h02d1;
  localparam logic [9:0]  err_offs   = 10'h155;
  localparam logic [13:0] rand_page  = 14'h0042;

  logic                   clkbd, rst_n;
  logic                   cpu_req, cpu_write, cpu_ack;
  logic [`BIF_PAGE_W-1:0] cpu_ppn;
  logic [`BIF_OFFS_W-1:0] cpu_ca;
  logic [`BIF_DATA_W-1:0] cpu_wdata, cpu_rdata, idb;
  logic                   bus_dap_n, bus_req, bus_write, bus_ack;
  logic [`BIF_LBD_W-1:0]  bd_in_n, bd_out_n;
  logic                   mem_req, mem_write, mem_ack, mem_err;
  logic [`BIF_LBD_W-1:0]  lbd_addr, lbd_wdata, mem_rdata;
  logic [1:0]             err_sel;
  logic                   err_clr;

  int          err_cnt, hs_err_cnt, cycle_cnt;
  integer      seed;
  logic [15:0] mem [0:1023];      // Local memory model
  logic [15:0] exp_mem [0:1023];  // Expected contents
  logic [23:0] acc_log [$];       // Address of each mem_req cycle
  logic [23:0] bad_addr;          // Address answered with mem_err
  owner_e      last_owner;

  `include "tb_bif_tasks.svh"

  bif_dpath i_dut (
    .clkbd(clkbd), .rst_n(rst_n),
    .cpu_req(cpu_req), .cpu_write(cpu_write), .cpu_ppn(cpu_ppn), .cpu_ca(cpu_ca),
    .cpu_wdata(cpu_wdata), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
    .bus_dap_n(bus_dap_n), .bus_req(bus_req), .bus_write(bus_write), .bd_in_n(bd_in_n),
    .bus_ack(bus_ack), .bd_out_n(bd_out_n),
    .mem_req(mem_req), .mem_write(mem_write), .lbd_addr(lbd_addr), .lbd_wdata(lbd_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_err(mem_err),
    .err_sel(err_sel), .err_clr(err_clr), .idb(idb)
  );

  initial begin
    clkbd = 1'b0;
    forever #20 clkbd = ~clkbd;  // 40 ns period
  end

  initial begin
    int i;
    for (i = 0; i < 1024; i++) begin
      mem[i]     = fill_word(i[9:0]);
      exp_mem[i] = fill_word(i[9:0]);
    end
    serve_memory();
  end

  task automatic reset_values();
    int s;
    check("cpu_ack", cpu_ack, 1'b0);
    check("bus_ack", bus_ack, 1'b0);
    check("mem_req", mem_req, 1'b0);
    check("bd_out_n", bd_out_n, 24'hffffff);
    for (s = 0; s < 4; s++) begin
      compare_idb(s[1:0], 16'h0000);
    end
  endtask

  // Both peers raise req on one edge and the winner follows the last owner
  task automatic collide_once(input logic wr, input logic [13:0] page, input logic [9:0] offs,
                              input logic [23:0] ext_addr, input logic [15:0] data);
    owner_e      first;
    int          base;
    logic [15:0] rd_c, rd_e;
    logic [23:0] cpu_addr;
    first    = (last_owner == owner_ext) ? owner_cpu : owner_ext;
    cpu_addr = page * 1024 + offs;
    base     = acc_log.size();
    fork
      begin
        @(posedge clkbd);  // Aligns cpu_req with bus_req
        cpu_access(wr, page, offs, data, rd_c);
      end
      ext_access(wr, ext_addr, ~data, rd_e);
    join
    last_owner = (first == owner_cpu) ? owner_ext : owner_cpu;  // Loser served last
    check("mem_req cycles", acc_log.size() - base, 2);
    check("first lbd_addr", acc_log[base], (first == owner_cpu) ? cpu_addr : ext_addr);
    check("second lbd_addr", acc_log[base + 1], (first == owner_cpu) ? ext_addr : cpu_addr);
  endtask

  task automatic collision_order();
    logic [15:0] rd;
    collide_once(1'b1, 14'h0123, 10'h011, 24'h00c222, 16'h1111);  // CPU first after reset
    cpu_access(1'b0, 14'h0123, 10'h011, 16'h0000, rd);             // CPU now last owner
    collide_once(1'b0, 14'h0123, 10'h011, 24'h00c222, 16'h0000);  // External first
  endtask

  task automatic cpu_write_read();
    logic [15:0] rd;
    int          base;
    base = acc_log.size();
    cpu_access(1'b1, 14'h01a7, 10'h2c3, 16'hbeef, rd);
    cpu_access(1'b0, 14'h01a7, 10'h2c3, 16'h0000, rd);
    check("cpu_rdata", rd, 16'hbeef);
    check("write lbd_addr", acc_log[base], 14'h01a7 * 1024 + 10'h2c3);
    check("read lbd_addr", acc_log[base + 1], 14'h01a7 * 1024 + 10'h2c3);
  endtask

  task automatic ext_write_read();
    logic [15:0] rd;
    int          base;
    base = acc_log.size();
    ext_access(1'b1, 14'h00f3 * 1024 + 10'h01e, 16'h5a17, rd);
    check("mem true data", mem[10'h01e], 16'h5a17);  // Stored non-inverted
    ext_access(1'b0, 14'h00f3 * 1024 + 10'h01e, 16'h0000, rd);
    check("ext read data", rd, 16'h5a17);
    check("ext lbd_addr", acc_log[base], 14'h00f3 * 1024 + 10'h01e);
  endtask

  task automatic error_capture();
    logic [15:0] rd;
    bad_addr = {err_page, err_offs};
    cpu_access(1'b1, err_page, err_offs, 16'hc0de, rd);
    compare_idb(2'd0, {1'b1, owner_cpu, 1'b1, 1'b0, 12'h000});
    compare_idb(2'd1, {2'b00, err_page});
    compare_idb(2'd2, {6'h00, err_offs});
    compare_idb(2'd3, 16'h0000);
    bad_addr = 24'h3ff001;  // Second error elsewhere
    ext_access(1'b0, 24'h3ff001, 16'h0000, rd);
    compare_idb(2'd0, {1'b1, owner_cpu, 1'b1, 1'b1, 12'h000});
    compare_idb(2'd1, {2'b00, err_page});  // First address kept
    compare_idb(2'd2, {6'h00, err_offs});
    @(posedge clkbd);
    err_clr <= 1'b1;
    @(posedge clkbd);
    err_clr <= 1'b0;
    compare_idb(2'd0, 16'h0000);
    compare_idb(2'd1, 16'h0000);
    compare_idb(2'd2, 16'h0000);
    compare_idb(2'd3, 16'h0000);
    bad_addr = {err_page, err_offs};
  endtask

  task automatic random_latency();
    int          i;
    logic        wr;
    logic [9:0]  offs;
    logic [15:0] data, rd;
    for (i = 0; i < n_rand; i++) begin
      wr   = $random(seed);
      offs = 10'h300 + ({$random(seed)} % 8);  // Small set so reads hit writes
      data = $random(seed);
      if ($random(seed) & 1) begin
        cpu_access(wr, rand_page, offs, data, rd);
      end else begin
        ext_access(wr, {rand_page, offs}, data, rd);
      end
    end
    for (i = 10'h300; i < 10'h308; i++) begin
      check($sformatf("mem[%0h]", i), mem[i], exp_mem[i]);
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clkbd);
      cycle_cnt++;
    end
    $display("Timeout at cycle %0d, %0d value errors, %0d handshake errors",
             cycle_cnt, err_cnt, hs_err_cnt);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    seed       = 32'h8c66d0ef;
    err_cnt    = 0;
    hs_err_cnt = 0;
    last_owner = owner_ext;  // CPU wins the first collision
    bad_addr   = {err_page, err_offs};
    rst_n      = 1'b0;
    cpu_req    = 1'b0;
    cpu_write  = 1'b0;
    cpu_ppn    = '0;
    cpu_ca     = '0;
    cpu_wdata  = '0;
    bus_dap_n  = 1'b1;
    bus_req    = 1'b0;
    bus_write  = 1'b0;
    bd_in_n    = '1;
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    mem_err    = 1'b0;
    err_sel    = 2'd0;
    err_clr    = 1'b0;
    repeat (5) @(posedge clkbd);
    rst_n <= 1'b1;
    @(posedge clkbd);
    reset_values();
    collision_order();
    cpu_write_read();
    ext_write_read();
    error_capture();
    random_latency();
    repeat (2) @(posedge clkbd);
    $display("Errors: %0d value mismatches, %0d handshake failures", err_cnt, hs_err_cnt);
    if (err_cnt == 0 && hs_err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
+incdir+tb
src/bif_bus_pkg.sv
src/bif_ctl_pkg.sv
src/bif_cpu_port.sv
src/bif_ext_port.sv
src/bif_lbd_arbiter.sv
src/bif_err_regs.sv
src/bif_dpath.sv
tb/tb_bif_dpath.sv
